// ==== hdl/div_isa_pkg.sv ====
package div_isa_pkg;

    // ##################################################
    // Operand width and M-extension division opcodes.
    // ##################################################

    localparam int unsigned XLEN = 64;

    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    // Special-case class, decided once at operand prep.
    typedef enum logic [1:0] {
        CASE_NORMAL   = 2'b00,
        CASE_DIV_ZERO = 2'b01,
        CASE_OVERFLOW = 2'b10
    } div_case_e;

    // ##################################################
    // Request, response and prepared operands.
    // ##################################################

    typedef struct packed {
        div_op_e          op;
        logic [XLEN-1:0]  dividend;
        logic [XLEN-1:0]  divisor;
    } div_req_t;

    typedef struct packed {
        logic [XLEN-1:0]  result;
    } div_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0]  dvd_mag;
        logic [XLEN-1:0]  dvs_mag;
        logic [XLEN-1:0]  dividend;
        div_op_e          op;
        logic             q_neg;
        logic             r_neg;
        div_case_e        div_case;
    } div_operands_t;

endpackage

// ==== hdl/div_ctrl_pkg.sv ====
package div_ctrl_pkg;

    // ##################################################
    // Controller states.
    // ##################################################

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_ITER  = 3'd1,
        ST_FIXUP = 3'd2,
        ST_ACK   = 3'd3,
        ST_DRAIN = 3'd4
    } div_state_e;

    // ##################################################
    // Iteration count.
    // ##################################################

    // One restoring step per quotient bit.
    localparam int unsigned DIV_STEPS = 64;

    // Wide enough to hold DIV_STEPS itself.
    localparam int unsigned STEP_CNT_W = 7;

endpackage

// ==== hdl/div_operand_prep.sv ====
`timescale 1ns/100ps

module div_operand_prep (
    input  logic                       clk,
    input  logic                       load_en,
    input  div_isa_pkg::div_req_t      req_data,
    output div_isa_pkg::div_operands_t opnd
);

    import div_isa_pkg::*;

    logic            is_signed;
    logic            dvd_neg;
    logic            dvs_neg;
    logic [XLEN-1:0] dvd_mag;
    logic [XLEN-1:0] dvs_mag;
    div_case_e       div_case;

    assign is_signed = (req_data.op == OP_DIV) || (req_data.op == OP_REM);

    // Sign bits only count for the signed ops.
    assign dvd_neg = is_signed & req_data.dividend[XLEN-1];
    assign dvs_neg = is_signed & req_data.divisor[XLEN-1];

    assign dvd_mag = dvd_neg ? (~req_data.dividend + 1'b1) : req_data.dividend;
    assign dvs_mag = dvs_neg ? (~req_data.divisor + 1'b1) : req_data.divisor;

    // Zero divisor wins over the overflow pattern.
    always_comb begin
        div_case = CASE_NORMAL;
        if (req_data.divisor == '0) begin
            div_case = CASE_DIV_ZERO;
        end else if (is_signed && (req_data.dividend == {1'b1, {(XLEN-1){1'b0}}})
                     && (req_data.divisor == '1)) begin
            div_case = CASE_OVERFLOW;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            opnd.dvd_mag  <= dvd_mag;
            opnd.dvs_mag  <= dvs_mag;
            opnd.dividend <= req_data.dividend;
            opnd.op       <= req_data.op;
            // Raw sign relations, the fixup gates them by op.
            opnd.q_neg    <= req_data.dividend[XLEN-1] ^ req_data.divisor[XLEN-1];
            opnd.r_neg    <= req_data.dividend[XLEN-1];
            opnd.div_case <= div_case;
        end
    end

endmodule

// ==== hdl/div_step_unit.sv ====
`timescale 1ns/100ps

module div_step_unit (
    input  logic                                 clk,
    input  logic                                 load_en,
    input  logic                                 step_en,
    input  div_isa_pkg::div_operands_t           opnd,
    output logic [div_isa_pkg::XLEN-1:0]         quo_mag,
    output logic [div_isa_pkg::XLEN-1:0]         rem_mag
);

    import div_isa_pkg::*;

    // ##################################################
    // Partial remainder and quotient register.
    // ##################################################

    // Upper half is the partial remainder, lower half shifts in quotient bits.
    logic [2*XLEN-1:0] part;

    // Operands are registered on the same edge as load_en, so the first
    // step draws the dividend magnitude straight from the prep register.
    logic              first_step;

    logic [2*XLEN-1:0] src;
    logic [2*XLEN:0]   shifted;
    logic [XLEN:0]     top;
    logic [XLEN:0]     trial;
    logic              fits;
    logic [2*XLEN-1:0] part_next;

    // ##################################################
    // One restoring step.
    // ##################################################

    assign src     = first_step ? {{XLEN{1'b0}}, opnd.dvd_mag} : part;
    assign shifted = {src, 1'b0};

    // Keep the bit shifted out, the remainder can exceed XLEN bits here.
    assign top   = shifted[2*XLEN:XLEN];
    assign trial = top - {1'b0, opnd.dvs_mag};
    assign fits  = ~trial[XLEN];

    always_comb begin
        if (fits) begin
            part_next = {trial[XLEN-1:0], shifted[XLEN-1:1], 1'b1};
        end else begin
            part_next = shifted[2*XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            part       <= '0;
            first_step <= 1'b1;
        end else if (step_en) begin
            part       <= part_next;
            first_step <= 1'b0;
        end
    end

    assign quo_mag = part[XLEN-1:0];
    assign rem_mag = part[2*XLEN-1:XLEN];

endmodule

// ==== hdl/div_result_fixup.sv ====
`timescale 1ns/100ps

module div_result_fixup (
    input  logic                         clk,
    input  logic                         fix_en,
    input  div_isa_pkg::div_operands_t   opnd,
    input  logic [div_isa_pkg::XLEN-1:0] quo_mag,
    input  logic [div_isa_pkg::XLEN-1:0] rem_mag,
    output div_isa_pkg::div_rsp_t        rsp
);

    import div_isa_pkg::*;

    logic            is_signed;
    logic            is_quo_op;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] result;

    assign is_signed = (opnd.op == OP_DIV) || (opnd.op == OP_REM);
    assign is_quo_op = (opnd.op == OP_DIV) || (opnd.op == OP_DIVU);

    // ##################################################
    // Sign correction and result select.
    // ##################################################

    assign quo = (is_signed && opnd.q_neg) ? (~quo_mag + 1'b1) : quo_mag;

    // Remainder follows the sign of the dividend.
    assign rem = (is_signed && opnd.r_neg) ? (~rem_mag + 1'b1) : rem_mag;

    always_comb begin
        case (opnd.div_case)
            CASE_DIV_ZERO: begin
                // Quotient all ones, remainder is the dividend.
                result = is_quo_op ? {XLEN{1'b1}} : opnd.dividend;
            end
            CASE_OVERFLOW: begin
                // Most negative over minus one.
                result = is_quo_op ? opnd.dividend : {XLEN{1'b0}};
            end
            default: begin
                result = is_quo_op ? quo : rem;
            end
        endcase
    end

    // Response holds until the next fix_en.
    always_ff @(posedge clk) begin
        if (fix_en) begin
            rsp.result <= result;
        end
    end

endmodule

// ==== hdl/div_ctrl.sv ====
`timescale 1ns/100ps

module div_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic flush,
    output logic ack,
    output logic load_en,
    output logic step_en,
    output logic fix_en
);

    import div_ctrl_pkg::*;

    div_state_e              state;
    div_state_e              state_next;
    logic [STEP_CNT_W-1:0]   step_cnt;
    logic                    last_step;

    // ##################################################
    // Datapath enables.
    // ##################################################

    // Operands are taken on the edge that sees req in idle.
    assign load_en = (state == ST_IDLE) && req;
    assign step_en = (state == ST_ITER);
    assign fix_en  = (state == ST_FIXUP);

    assign ack = (state == ST_ACK);

    // True during the cycle that performs the final step.
    assign last_step = (step_cnt == STEP_CNT_W'(DIV_STEPS - 1));

    // ##################################################
    // Sequencing FSM.
    // ##################################################

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_next = ST_ITER;
                end
            end
            ST_ITER: begin
                if (last_step) begin
                    state_next = ST_FIXUP;
                end
            end
            ST_FIXUP: begin
                state_next = ST_ACK;
            end
            ST_ACK: begin
                // Four-phase, hold ack until the requester lets go.
                if (!req) begin
                    state_next = ST_IDLE;
                end
            end
            ST_DRAIN: begin
                // Aborted request must not be taken again.
                if (!req) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase

        // Flush aborts anything in flight.
        if (flush && (state != ST_IDLE) && (state != ST_DRAIN)) begin
            state_next = ST_DRAIN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            step_cnt <= '0;
        end else begin
            state <= state_next;
            if (load_en) begin
                step_cnt <= '0;
            end else if (step_en) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/div_unit_top.sv ====
`timescale 1ns/100ps

module div_unit_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  div_isa_pkg::div_req_t req_data,
    input  logic                  flush,
    output logic                  ack,
    output div_isa_pkg::div_rsp_t rsp
);

    import div_isa_pkg::*;

    // ##################################################
    // Internal wiring.
    // ##################################################

    logic            load_en;
    logic            step_en;
    logic            fix_en;
    div_operands_t   opnd;
    logic [XLEN-1:0] quo_mag;
    logic [XLEN-1:0] rem_mag;

    // ##################################################
    // Control.
    // ##################################################

    div_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .flush   (flush),
        .ack     (ack),
        .load_en (load_en),
        .step_en (step_en),
        .fix_en  (fix_en)
    );

    // ##################################################
    // Datapath.
    // ##################################################

    div_operand_prep u_prep (
        .clk      (clk),
        .load_en  (load_en),
        .req_data (req_data),
        .opnd     (opnd)
    );

    div_step_unit u_step (
        .clk     (clk),
        .load_en (load_en),
        .step_en (step_en),
        .opnd    (opnd),
        .quo_mag (quo_mag),
        .rem_mag (rem_mag)
    );

    div_result_fixup u_fixup (
        .clk     (clk),
        .fix_en  (fix_en),
        .opnd    (opnd),
        .quo_mag (quo_mag),
        .rem_mag (rem_mag),
        .rsp     (rsp)
    );

endmodule

// ==== dv/div_tb_clkgen.sv ====
`timescale 1ns/100ps

module div_tb_clkgen (
    output logic clk
);

    // Free-running clock, 100 ns period.
    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

// ==== dv/div_unit_chk.sv ====
`timescale 1ns/100ps

module div_unit_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  req,
    input logic                  flush,
    input logic                  ack,
    input div_isa_pkg::div_rsp_t rsp
);

    // ##################################################
    // Handshake rules.
    // ##################################################

    // Req is looked at on the edge that raised ack.
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // Response is frozen for as long as ack stays up.
    rsp_stable_under_ack: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(rsp))
        else $error("rsp changed while ack was high");

    ack_low_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !ack)
        else $error("ack still high in the cycle after flush");

    ack_low_after_reset: assert property (@(posedge clk)
        rst |=> !ack)
        else $error("ack high in the cycle after reset");

endmodule

bind div_unit_top div_unit_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .flush (flush),
    .ack   (ack),
    .rsp   (rsp)
);

// ==== dv/div_tb.sv ====
`timescale 1ns/100ps

module div_tb;

    import div_isa_pkg::*;

    localparam int LATENCY = 66;
    localparam int WAIT_LIMIT = 200;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic        clk;
    logic        rst;
    logic        req;
    logic        flush;
    logic        ack;
    div_req_t    req_data;
    div_rsp_t    rsp;
    logic [31:0] lcg_state;

    div_tb_clkgen u_clkgen (
        .clk (clk)
    );

    div_unit_top dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .flush    (flush),
        .ack      (ack),
        .rsp      (rsp)
    );

    // ##################################################
    // Reference model and random source.
    // ##################################################

    // RISC-V M-extension rules, including both special cases.
    function automatic div_rsp_t ref_div(div_req_t r);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   want_quo;
        div_rsp_t               res;
        sa = r.dividend;
        sb = r.divisor;
        want_quo = (r.op == OP_DIV) || (r.op == OP_DIVU);
        if (r.divisor == '0) begin
            res.result = want_quo ? {XLEN{1'b1}} : r.dividend;
        end else if ((r.op == OP_DIV || r.op == OP_REM) && r.dividend == MOST_NEG
                     && r.divisor == {XLEN{1'b1}}) begin
            res.result = want_quo ? r.dividend : {XLEN{1'b0}};
        end else begin
            case (r.op)
                OP_DIV:  res.result = sa / sb;
                OP_REM:  res.result = sa % sb;
                OP_DIVU: res.result = r.dividend / r.divisor;
                default: res.result = r.dividend % r.divisor;
            endcase
        end
        return res;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    // ##################################################
    // Failure reporting and compare tasks.
    // ##################################################

    task automatic fail_stop(string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_rsp(string name, div_rsp_t got, div_rsp_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_latency(int got, int exp);
        if (got != exp) begin
            fail_stop($sformatf("[FAIL] req-to-ack latency got %h expected %h", got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // ##################################################
    // Four-phase transaction.
    // ##################################################

    // Hold adds extra cycles of req after ack to exercise back-pressure.
    task automatic run_op(div_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b, int hold);
        div_req_t r;
        div_rsp_t exp;
        int       cnt;
        r.op = op;
        r.dividend = a;
        r.divisor = b;
        exp = ref_div(r);
        req_data = r;
        req = 1'b1;
        cnt = 0;
        do begin
            next_cycle();
            cnt++;
            if (cnt >= WAIT_LIMIT && !ack) begin
                fail_stop("Timed out waiting for ack to rise.");
            end
        end while (!ack);
        check_latency(cnt, LATENCY);
        check_rsp("rsp", rsp, exp);
        for (int i = 0; i < hold; i++) begin
            next_cycle();
            if (!ack) begin
                fail_stop("ack dropped while req was still held high.");
            end
            check_rsp("rsp", rsp, exp);
        end
        req = 1'b0;
        cnt = 0;
        do begin
            next_cycle();
            cnt++;
            if (cnt >= WAIT_LIMIT && ack) begin
                fail_stop("Timed out waiting for ack to fall.");
            end
        end while (ack);
    endtask

    // ##################################################
    // Directed tests.
    // ##################################################

    task automatic test_unsigned();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0]     sh;
        run_op(OP_DIVU, 64'd100, 64'd7, 0);
        run_op(OP_REMU, 64'd100, 64'd7, 0);
        // Dividend below divisor.
        run_op(OP_DIVU, 64'd7, 64'd100, 0);
        run_op(OP_REMU, 64'd7, 64'd100, 0);
        run_op(OP_DIVU, {XLEN{1'b1}}, 64'd3, 0);
        run_op(OP_REMU, MOST_NEG, 64'd2, 0);
        for (int i = 0; i < 8; i++) begin
            a = rand64();
            sh = lcg_next();
            b = rand64() >> sh[5:0];
            run_op(OP_DIVU, a, b, 0);
            run_op(OP_REMU, a, b, 0);
        end
    endtask

    task automatic test_signed();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0]     sh;
        run_op(OP_DIV, 64'd100, 64'd7, 0);
        run_op(OP_REM, 64'd100, 64'd7, 0);
        run_op(OP_DIV, -64'sd100, 64'd7, 0);
        run_op(OP_REM, -64'sd100, 64'd7, 0);
        run_op(OP_DIV, 64'd100, -64'sd7, 0);
        run_op(OP_REM, 64'd100, -64'sd7, 0);
        run_op(OP_DIV, -64'sd100, -64'sd7, 0);
        run_op(OP_REM, -64'sd100, -64'sd7, 0);
        for (int i = 0; i < 8; i++) begin
            a = rand64();
            sh = lcg_next();
            b = $signed(rand64()) >>> sh[5:0];
            run_op(OP_DIV, a, b, 0);
            run_op(OP_REM, a, b, 0);
        end
    endtask

    task automatic test_special();
        run_op(OP_DIV, 64'h1234_5678_9abc_def0, 64'd0, 0);
        run_op(OP_DIVU, 64'h1234_5678_9abc_def0, 64'd0, 0);
        run_op(OP_REM, -64'sd55, 64'd0, 0);
        run_op(OP_REMU, 64'hfedc_ba98_7654_3210, 64'd0, 0);
        run_op(OP_DIV, MOST_NEG, {XLEN{1'b1}}, 0);
        run_op(OP_REM, MOST_NEG, {XLEN{1'b1}}, 0);
    endtask

    task automatic test_backpressure();
        run_op(OP_DIV, -64'sd1000, 64'd33, 20);
        run_op(OP_REMU, 64'hdead_beef_0000_1111, 64'h1_0001, 20);
    endtask

    task automatic test_flush();
        int cnt;
        req_data.op = OP_DIVU;
        req_data.dividend = 64'd999;
        req_data.divisor = 64'd3;
        req = 1'b1;
        for (int i = 0; i < 10; i++) begin
            next_cycle();
        end
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        // Aborted request must never complete while req is still held.
        for (int i = 0; i < 100; i++) begin
            next_cycle();
            if (ack) begin
                fail_stop("ack rose for a flushed request.");
            end
        end
        req = 1'b0;
        next_cycle();
        run_op(OP_REM, -64'sd77, 64'd5, 0);
        // A flush while ack is held up drops it on the next edge.
        req_data.op = OP_DIV;
        req_data.dividend = -64'sd500;
        req_data.divisor = 64'd9;
        req = 1'b1;
        cnt = 0;
        do begin
            next_cycle();
            cnt++;
            if (cnt >= WAIT_LIMIT && !ack) begin
                fail_stop("Timed out waiting for ack before the flush.");
            end
        end while (!ack);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        if (ack) begin
            fail_stop("ack still high right after a flush during ack.");
        end
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            if (ack) begin
                fail_stop("ack came back for a flushed request.");
            end
        end
        req = 1'b0;
        next_cycle();
        run_op(OP_DIVU, 64'd999, 64'd3, 0);
    endtask

    initial begin
        lcg_state = 32'haade7325;
        rst = 1'b1;
        req = 1'b0;
        flush = 1'b0;
        req_data = '0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        next_cycle();
        test_unsigned();
        test_signed();
        test_special();
        test_backpressure();
        test_flush();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/div_isa_pkg.sv
hdl/div_ctrl_pkg.sv
hdl/div_operand_prep.sv
hdl/div_step_unit.sv
hdl/div_result_fixup.sv
hdl/div_ctrl.sv
hdl/div_unit_top.sv
dv/div_tb_clkgen.sv
dv/div_unit_chk.sv
dv/div_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module div_tb \
    --Mdir obj_dir \
    -o div_sim

./obj_dir/div_sim
